// File: logic/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// first fetch address after reset
`define RESET_PC 32'hbfc0_0000

// general registers including r0
`define REG_COUNT 32

`endif

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // data word or byte address
    typedef logic [31:0] word_t;

    // general register number
    typedef logic [4:0] reg_addr_t;

    // drop state eats one response left over from a squashed path
    typedef enum logic {
        FETCH_RUN,
        FETCH_DROP
    } fetch_state_t;

endpackage

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_t;

    // SPECIAL function codes in bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_NONE
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_t;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module fetch_unit import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  iresp_addr_ok,
    input  wire word_t iresp_data,
    input  wire logic  redirect_valid,
    input  wire word_t redirect_pc,
    output logic       ireq_valid,
    output word_t      ireq_addr,
    output logic       f2_valid,
    output word_t      f2_pc,
    output word_t      f2_instr
);

    word_t        pc;
    word_t        req_pc;
    logic         running;
    logic         resp_pending;
    logic         accept;
    fetch_state_t state;

    // request line stays up once out of reset
    assign ireq_valid = running;
    assign ireq_addr  = pc;
    assign accept     = ireq_valid && iresp_addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // redirect wins over the sequential step
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_pending <= 1'b0;
            state        <= FETCH_RUN;
        end else begin
            resp_pending <= accept;
            // accepted this cycle but already on the wrong path
            if (redirect_valid && accept) begin
                state <= FETCH_DROP;
            end else begin
                state <= FETCH_RUN;
            end
        end
    end

    // pc of the accepted request pairs with its data next cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc <= pc;
        end
    end

    assign f2_valid = resp_pending && (state == FETCH_RUN);
    assign f2_pc    = req_pc;
    assign f2_instr = iresp_data;

endmodule

`default_nettype wire

// File: logic/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import isa_pkg::*; import core_pkg::*; (
    input  wire word_t instr,
    input  wire logic  valid,
    output alu_op_t    alu_op,
    output branch_t    branch,
    output reg_addr_t  rs,
    output reg_addr_t  rt,
    output reg_addr_t  dest,
    output logic       reg_write,
    output logic       use_imm,
    output word_t      imm
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd;
    logic      writes;
    word_t     imm_sext;
    word_t     imm_zext;

    assign opcode   = opcode_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    always_comb begin
        alu_op  = ALU_NONE;
        branch  = BR_NONE;
        dest    = '0;
        writes  = 1'b0;
        use_imm = 1'b0;
        imm     = imm_sext;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: alu_op = ALU_NONE;
                endcase
                // unknown funct stays a no-op
                if (alu_op != ALU_NONE) begin
                    dest   = rd;
                    writes = 1'b1;
                end
            end
            OP_ADDIU: begin
                alu_op  = ALU_ADD;
                dest    = rt;
                writes  = 1'b1;
                use_imm = 1'b1;
            end
            OP_ORI: begin
                alu_op  = ALU_OR;
                dest    = rt;
                writes  = 1'b1;
                use_imm = 1'b1;
                imm     = imm_zext;
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                dest    = rt;
                writes  = 1'b1;
                use_imm = 1'b1;
                imm     = imm_zext;
            end
            OP_BEQ:  branch = BR_EQ;
            OP_BNE:  branch = BR_NE;
            default: alu_op = ALU_NONE;
        endcase
        // empty slot neither writes nor branches
        if (!valid) begin
            branch = BR_NONE;
            writes = 1'b0;
        end
    end

    // r0 is never written
    assign reg_write = writes && (dest != '0);

endmodule

`default_nettype wire

// File: logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module regfile import core_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire reg_addr_t rs,
    input  wire reg_addr_t rt,
    input  wire logic      wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire word_t     wr_data,
    output word_t          rs_data,
    output word_t          rt_data
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so D sees what W writes this cycle
    always_comb begin
        rs_data = regs[rs];
        if (wr_en && (wr_addr == rs) && (rs != '0)) begin
            rs_data = wr_data;
        end
    end

    always_comb begin
        rt_data = regs[rt];
        if (wr_en && (wr_addr == rt) && (rt != '0)) begin
            rt_data = wr_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import isa_pkg::*; import core_pkg::*; (
    input  wire logic      valid,
    input  wire word_t     pc,
    input  wire alu_op_t   alu_op,
    input  wire branch_t   branch,
    input  wire reg_addr_t rs,
    input  wire reg_addr_t rt,
    input  wire word_t     rs_data,
    input  wire word_t     rt_data,
    input  wire logic      use_imm,
    input  wire word_t     imm,
    input  wire logic      w_write,
    input  wire reg_addr_t w_dest,
    input  wire word_t     w_data,
    output word_t          result,
    output logic           redirect_valid,
    output word_t          redirect_pc
);

    word_t src_a;
    word_t src_b;
    word_t opnd_b;
    logic  taken;

    // W holds the instruction just ahead and is newer than the value read in D
    assign src_a  = (w_write && (w_dest == rs) && (rs != '0)) ? w_data : rs_data;
    assign src_b  = (w_write && (w_dest == rt) && (rt != '0)) ? w_data : rt_data;
    assign opnd_b = use_imm ? imm : src_b;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = src_a + opnd_b;
            ALU_SUB: result = src_a - opnd_b;
            ALU_AND: result = src_a & opnd_b;
            ALU_OR:  result = src_a | opnd_b;
            ALU_XOR: result = src_a ^ opnd_b;
            ALU_SLT: result = {31'd0, $signed(src_a) < $signed(opnd_b)};
            ALU_LUI: result = {opnd_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // branches compare the two register operands
    always_comb begin
        case (branch)
            BR_EQ:   taken = (src_a == src_b);
            BR_NE:   taken = (src_a != src_b);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_valid = valid && taken;
    // target is relative to pc + 4 with no delay slot
    assign redirect_pc    = pc + 32'd4 + {imm[29:0], 2'b00};

endmodule

`default_nettype wire

// File: logic/my_core.sv
`timescale 1ns/1ps
`default_nettype none

module my_core import isa_pkg::*; import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  iresp_addr_ok,
    input  wire word_t iresp_data,
    output logic       ireq_valid,
    output word_t      ireq_addr,
    output logic       debug_wb_valid,
    output word_t      debug_wb_pc,
    output logic       debug_wb_we,
    output reg_addr_t  debug_wb_num,
    output word_t      debug_wb_data
);

    logic      f2_valid;
    word_t     f2_pc;
    word_t     f2_instr;
    logic      redirect_valid;
    word_t     redirect_pc;

    // D stage
    logic      d_valid;
    word_t     d_pc;
    word_t     d_instr;
    alu_op_t   d_alu_op;
    branch_t   d_branch;
    reg_addr_t d_rs;
    reg_addr_t d_rt;
    reg_addr_t d_dest;
    logic      d_reg_write;
    logic      d_use_imm;
    word_t     d_imm;
    word_t     d_rs_data;
    word_t     d_rt_data;

    // E stage
    logic      e_valid;
    word_t     e_pc;
    alu_op_t   e_alu_op;
    branch_t   e_branch;
    reg_addr_t e_rs;
    reg_addr_t e_rt;
    reg_addr_t e_dest;
    logic      e_reg_write;
    logic      e_use_imm;
    word_t     e_imm;
    word_t     e_rs_data;
    word_t     e_rt_data;
    word_t     e_result;

    // W stage
    logic      w_valid;
    word_t     w_pc;
    logic      w_write;
    reg_addr_t w_dest;
    word_t     w_data;

    fetch_unit u_fetch (
        .clk,
        .reset,
        .iresp_addr_ok,
        .iresp_data,
        .redirect_valid,
        .redirect_pc,
        .ireq_valid,
        .ireq_addr,
        .f2_valid,
        .f2_pc,
        .f2_instr
    );

    // a taken branch in E squashes the F2 response and the D slot
    always_ff @(posedge clk) begin
        if (reset || redirect_valid) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= f2_valid;
        end
    end

    always_ff @(posedge clk) begin
        d_pc    <= f2_pc;
        d_instr <= f2_instr;
    end

    decoder u_decoder (
        .instr     (d_instr),
        .valid     (d_valid),
        .alu_op    (d_alu_op),
        .branch    (d_branch),
        .rs        (d_rs),
        .rt        (d_rt),
        .dest      (d_dest),
        .reg_write (d_reg_write),
        .use_imm   (d_use_imm),
        .imm       (d_imm)
    );

    regfile u_regfile (
        .clk,
        .reset,
        .rs      (d_rs),
        .rt      (d_rt),
        .wr_en   (w_write),
        .wr_addr (w_dest),
        .wr_data (w_data),
        .rs_data (d_rs_data),
        .rt_data (d_rt_data)
    );

    always_ff @(posedge clk) begin
        if (reset || redirect_valid) begin
            e_valid     <= 1'b0;
            e_reg_write <= 1'b0;
        end else begin
            e_valid     <= d_valid;
            e_reg_write <= d_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        e_pc      <= d_pc;
        e_alu_op  <= d_alu_op;
        e_branch  <= d_branch;
        e_rs      <= d_rs;
        e_rt      <= d_rt;
        e_dest    <= d_dest;
        e_use_imm <= d_use_imm;
        e_imm     <= d_imm;
        e_rs_data <= d_rs_data;
        e_rt_data <= d_rt_data;
    end

    execute u_execute (
        .valid          (e_valid),
        .pc             (e_pc),
        .alu_op         (e_alu_op),
        .branch         (e_branch),
        .rs             (e_rs),
        .rt             (e_rt),
        .rs_data        (e_rs_data),
        .rt_data        (e_rt_data),
        .use_imm        (e_use_imm),
        .imm            (e_imm),
        .w_write        (w_write),
        .w_dest         (w_dest),
        .w_data         (w_data),
        .result         (e_result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // the branch itself still retires
    always_ff @(posedge clk) begin
        if (reset) begin
            w_valid <= 1'b0;
            w_write <= 1'b0;
        end else begin
            w_valid <= e_valid;
            w_write <= e_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        w_pc   <= e_pc;
        w_dest <= e_dest;
        w_data <= e_result;
    end

    // trace of each retired instruction
    assign debug_wb_valid = w_valid;
    assign debug_wb_pc    = w_pc;
    assign debug_wb_we    = w_write;
    assign debug_wb_num   = w_dest;
    assign debug_wb_data  = w_data;

endmodule

`default_nettype wire

// File: tb/core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module core_assertions import core_pkg::*; (
    input wire logic      clk,
    input wire logic      reset,
    input wire logic      ireq_valid,
    input wire logic      iresp_addr_ok,
    input wire word_t     ireq_addr,
    input wire logic      redirect_valid,
    input wire logic      debug_wb_we,
    input wire reg_addr_t debug_wb_num
);

    int unsigned fail_count = 0;

    // a waiting request keeps its address unless a taken branch moves the pc
    addr_held: assert property (@(posedge clk) disable iff (reset)
        ireq_valid && !iresp_addr_ok && !redirect_valid |=> $stable(ireq_addr))
        else begin
            $error("instruction address changed while its request waited");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !ireq_valid)
        else begin
            $error("fetch request raised in the first cycle after reset");
            fail_count++;
        end

    // r0 never shows up as a written register
    no_r0_write: assert property (@(posedge clk) disable iff (reset)
        debug_wb_we |-> (debug_wb_num != '0))
        else begin
            $error("trace reports a write to register 0");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tb/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_tb import isa_pkg::*; import core_pkg::*; ();

    localparam int PROG_LEN     = 200;
    localparam int END_WORDS    = PROG_LEN + 8;
    localparam int RESET_CYCLES = 16;
    localparam logic [5:0] FUNCTS [6] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};

    logic        clk;
    logic        reset;
    logic        iresp_addr_ok;
    word_t       iresp_data;
    logic        ireq_valid;
    word_t       ireq_addr;
    logic        debug_wb_valid;
    word_t       debug_wb_pc;
    logic        debug_wb_we;
    reg_addr_t   debug_wb_num;
    word_t       debug_wb_data;

    word_t       prog [PROG_LEN];
    word_t       model_regs [`REG_COUNT];
    word_t       model_pc;
    logic        done;
    int unsigned retired;

    my_core DUT (
        .clk,
        .reset,
        .iresp_addr_ok,
        .iresp_data,
        .ireq_valid,
        .ireq_addr,
        .debug_wb_valid,
        .debug_wb_pc,
        .debug_wb_we,
        .debug_wb_num,
        .debug_wb_data
    );

    bind my_core core_assertions u_assertions (
        .clk,
        .reset,
        .ireq_valid,
        .iresp_addr_ok,
        .ireq_addr,
        .redirect_valid,
        .debug_wb_we,
        .debug_wb_num
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // small register range so dependencies are frequent
    function automatic word_t random_instr();
        int unsigned kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        kind = $urandom_range(0, 99);
        rs   = 5'($urandom_range(0, 7));
        rt   = 5'($urandom_range(0, 7));
        rd   = 5'($urandom_range(0, 7));
        imm  = 16'($urandom);
        if (kind < 40) begin
            return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNCTS[3'($urandom_range(0, 5))]};
        end else if (kind < 52) begin
            return {OP_ADDIU, rs, rt, imm};
        end else if (kind < 62) begin
            return {OP_ORI, rs, rt, imm};
        end else if (kind < 70) begin
            return {OP_LUI, 5'd0, rt, imm};
        end else if (kind < 90) begin
            // forward only by 0 to 6 instructions past the fall-through
            imm = 16'($urandom_range(0, 6));
            return {(kind < 80) ? OP_BEQ : OP_BNE, 5'(rs[1:0]), 5'(rt[1:0]), imm};
        end else if (kind < 95) begin
            return {6'h3f, rs, rt, imm};
        end
        return {OP_SPECIAL, rs, rt, rd, 5'd0, 6'h3e};
    endfunction

    // zeros past the program decode as no-ops
    function automatic word_t fetch_word(input word_t addr);
        word_t index;
        index = (addr - `RESET_PC) >> 2;
        if (index < PROG_LEN) begin
            return prog[index[7:0]];
        end
        return '0;
    endfunction

    task automatic retire_step();
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      data;
        word_t      next_pc;
        logic [5:0] op;
        reg_addr_t  num;
        logic       we;
        instr   = fetch_word(model_pc);
        op      = instr[31:26];
        a       = model_regs[instr[25:21]];
        b       = model_regs[instr[20:16]];
        sext    = {{16{instr[15]}}, instr[15:0]};
        we      = 1'b1;
        num     = instr[20:16];
        data    = '0;
        next_pc = model_pc + 32'd4;
        case (op)
            OP_SPECIAL: begin
                num = instr[15:11];
                case (instr[5:0])
                    FN_ADDU: data = a + b;
                    FN_SUBU: data = a - b;
                    FN_AND:  data = a & b;
                    FN_OR:   data = a | b;
                    FN_XOR:  data = a ^ b;
                    FN_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: we = 1'b0;
                endcase
            end
            OP_ADDIU: data = a + sext;
            OP_ORI:   data = a | {16'h0000, instr[15:0]};
            OP_LUI:   data = {instr[15:0], 16'h0000};
            OP_BEQ: begin
                we = 1'b0;
                if (a == b) begin
                    next_pc = model_pc + 32'd4 + (sext << 2);
                end
            end
            OP_BNE: begin
                we = 1'b0;
                if (a != b) begin
                    next_pc = model_pc + 32'd4 + (sext << 2);
                end
            end
            default: we = 1'b0;
        endcase
        if (num == '0) begin
            we = 1'b0;
        end
        check($sformatf("retire %0d pc", retired), model_pc, debug_wb_pc);
        check($sformatf("retire %0d we", retired), 32'(we), 32'(debug_wb_we));
        if (we) begin
            check($sformatf("retire %0d num", retired), 32'(num), 32'(debug_wb_num));
            check($sformatf("retire %0d data", retired), data, debug_wb_data);
            model_regs[num] = data;
        end
        model_pc = next_pc;
        retired++;
        if (model_pc >= `RESET_PC + 4 * END_WORDS) begin
            done = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        void'($urandom(32'h7da8));
        reset         = 1'b1;
        iresp_addr_ok = 1'b0;
        iresp_data    = '0;
        done          = 1'b0;
        retired       = 0;
        model_pc      = `RESET_PC;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = random_instr();
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        check("reset ireq_valid", 32'd0, 32'(ireq_valid));
        check("reset debug_wb_valid", 32'd0, 32'(debug_wb_valid));
        reset = 1'b0;
        @(posedge clk);
        #2;
        check("first ireq_valid", 32'd1, 32'(ireq_valid));
        check("first fetch address", `RESET_PC, ireq_addr);
        wait (done);
        repeat (2) @(posedge clk);
        if (DUT.u_assertions.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d bus or trace assertions failed", DUT.u_assertions.fail_count);
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end
    end

    // memory model where data follows acceptance by one cycle
    initial begin
        logic  pending;
        word_t pending_addr;
        pending      = 1'b0;
        pending_addr = '0;
        forever begin
            @(posedge clk);
            #2;
            iresp_data    = pending ? fetch_word(pending_addr) : $urandom;
            iresp_addr_ok = ($urandom_range(0, 99) < 60);
            pending       = ireq_valid && iresp_addr_ok;
            pending_addr  = ireq_addr;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!reset && debug_wb_valid && !done) begin
                retire_step();
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (DUT.u_assertions.fail_count != 0) begin
                $display("a bus or trace assertion failed before %0t", $time);
                $display(">>> FAIL");
                $fatal(1, "assertion failure");
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + 20 * PROG_LEN) @(posedge clk);
        $display("timeout: program did not finish within %0d cycles", 20 * PROG_LEN);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/core_pkg.sv
logic/isa_pkg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/regfile.sv
logic/execute.sv
logic/my_core.sv
tb/core_assertions.sv
tb/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
